// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;
    localparam int REG_SIZE  = 5;

    // Access size
    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_type_e;

    // Where the store data comes from
    typedef enum logic [1:0] {
        NO_BYPASS,
        BY_WB,
        BY_MEM
    } bypass_e;

    typedef struct packed {
        logic [ADDR_SIZE-1:0] addr;
        logic                 rd;
        logic                 wr;
        logic                 sign_ext;
        memop_type_e          mtype;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic [WORD_SIZE-1:0] st_data;
        logic [3:0]           byte_sel;
    } tl_req_t;

    // Data cache bus controller
    typedef enum logic [1:0] {
        C_IDLE,
        C_REFILL,
        C_WRITE
    } cache_state_e;

endpackage : mem_pkg

// ==== verilog/tl_req_if.sv ====
`timescale 1ns/1ps

interface tl_req_if;

    mem_pkg::tl_req_t req;
    logic             valid;
    // Holds the TL stage on a miss or a blocked store
    logic             stall;

    modport src (
        output req,
        output valid,
        output stall
    );

    modport cache (
        input req,
        input valid
    );

    modport sb (
        input req,
        input valid,
        input stall
    );

    modport align (
        input req,
        input valid,
        input stall
    );

endinterface : tl_req_if

// ==== verilog/sb_drain_if.sv ====
`timescale 1ns/1ps

interface sb_drain_if;

    logic                          valid;
    logic [mem_pkg::ADDR_SIZE-1:0] addr;
    logic [mem_pkg::WORD_SIZE-1:0] data;
    logic [3:0]                    sel;
    // Write accepted by memory, entry frees on this edge
    logic                          done;

    modport sb (
        output valid,
        output addr,
        output data,
        output sel,
        input  done
    );

    modport cache (
        input  valid,
        input  addr,
        input  data,
        input  sel,
        output done
    );

endinterface : sb_drain_if

// ==== verilog/dcache_lookup.sv ====
`timescale 1ns/1ps

module dcache_lookup #(
    parameter int CACHE_LINES = 16
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    tl_req_if.cache                       tl,
    sb_drain_if.cache                     drain,
    output logic [mem_pkg::WORD_SIZE-1:0] data_o,
    output logic                          hit_o,
    output logic                          miss_o,
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic                          wb_we_o,
    output logic [mem_pkg::ADDR_SIZE-1:0] wb_adr_o,
    output logic [mem_pkg::WORD_SIZE-1:0] wb_dat_o,
    output logic [3:0]                    wb_sel_o,
    input  logic [mem_pkg::WORD_SIZE-1:0] wb_dat_i,
    input  logic                          wb_ack_i
);

    localparam int INDEX_W = $clog2(CACHE_LINES);
    localparam int TAG_W   = mem_pkg::ADDR_SIZE - 2 - INDEX_W;

    mem_pkg::cache_state_e state_q;
    mem_pkg::cache_state_e state_d;

    logic [CACHE_LINES-1:0]        valid_q;
    logic [TAG_W-1:0]              tag_q  [CACHE_LINES];
    logic [mem_pkg::WORD_SIZE-1:0] data_q [CACHE_LINES];

    logic [INDEX_W-1:0] tl_index;
    logic [TAG_W-1:0]   tl_tag;
    logic [INDEX_W-1:0] dr_index;
    logic [TAG_W-1:0]   dr_tag;
    logic               sb_cover;
    logic               refill_done;
    logic               write_done;

    assign tl_index = tl.req.addr[INDEX_W+1:2];
    assign tl_tag   = tl.req.addr[mem_pkg::ADDR_SIZE-1:INDEX_W+2];
    assign dr_index = drain.addr[INDEX_W+1:2];
    assign dr_tag   = drain.addr[mem_pkg::ADDR_SIZE-1:INDEX_W+2];

    assign hit_o  = valid_q[tl_index] && (tag_q[tl_index] == tl_tag);
    assign data_o = data_q[tl_index];

    // Pending store already supplies every requested byte
    assign sb_cover = drain.valid
                   && (drain.addr[mem_pkg::ADDR_SIZE-1:2] == tl.req.addr[mem_pkg::ADDR_SIZE-1:2])
                   && ((drain.sel & tl.req.byte_sel) == tl.req.byte_sel);

    assign miss_o = tl.valid && tl.req.rd && !hit_o && !sb_cover;

    assign refill_done = (state_q == mem_pkg::C_REFILL) && wb_ack_i;
    assign write_done  = (state_q == mem_pkg::C_WRITE) && wb_ack_i;
    assign drain.done  = write_done;

    // Refill wins over a waiting drain
    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::C_IDLE: begin
                if (miss_o) begin
                    state_d = mem_pkg::C_REFILL;
                end else if (drain.valid) begin
                    state_d = mem_pkg::C_WRITE;
                end
            end
            mem_pkg::C_REFILL, mem_pkg::C_WRITE: begin
                if (wb_ack_i) begin
                    state_d = mem_pkg::C_IDLE;
                end
            end
            default: state_d = mem_pkg::C_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= mem_pkg::C_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (refill_done) begin
                valid_q[tl_index] <= 1'b1;
            end
        end
    end

    // Without write allocate only a resident line takes the store bytes
    always_ff @(posedge clk_i) begin
        if (refill_done) begin
            tag_q[tl_index]  <= tl_tag;
            data_q[tl_index] <= wb_dat_i;
        end else if (write_done && valid_q[dr_index] && (tag_q[dr_index] == dr_tag)) begin
            for (int b = 0; b < 4; b++) begin
                if (drain.sel[b]) begin
                    data_q[dr_index][8*b +: 8] <= drain.data[8*b +: 8];
                end
            end
        end
    end

    assign wb_cyc_o = (state_q != mem_pkg::C_IDLE);
    assign wb_stb_o = wb_cyc_o;
    assign wb_we_o  = (state_q == mem_pkg::C_WRITE);
    assign wb_adr_o = wb_we_o ? drain.addr : {tl.req.addr[mem_pkg::ADDR_SIZE-1:2], 2'b00};
    assign wb_dat_o = drain.data;
    assign wb_sel_o = wb_we_o ? drain.sel : 4'b1111;

    // Request fields come from the TL register and the store buffer
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_stb_o && !wb_ack_i |=> wb_stb_o && $stable(wb_adr_o) && $stable(wb_we_o)
                                  && $stable(wb_sel_o));

endmodule : dcache_lookup

// ==== verilog/store_buffer.sv ====
`timescale 1ns/1ps

module store_buffer (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    tl_req_if.sb                          tl,
    sb_drain_if.sb                        drain,
    output logic                          hit_o,
    output logic [mem_pkg::WORD_SIZE-1:0] data_o,
    output logic [3:0]                    mask_o,
    output logic                          full_block_o
);

    logic                          valid_q;
    logic [mem_pkg::ADDR_SIZE-3:0] waddr_q;
    logic [mem_pkg::WORD_SIZE-1:0] data_q;
    logic [3:0]                    mask_q;
    logic                          capture;
    logic [mem_pkg::WORD_SIZE-1:0] lane_data;

    assign capture = tl.valid && tl.req.wr && !tl.stall;

    // Store data moved onto its byte lanes
    assign lane_data = tl.req.st_data << {tl.req.addr[1:0], 3'b000};

    // A new store may take the entry on the edge it drains
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (capture) begin
            valid_q <= 1'b1;
        end else if (drain.done) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            waddr_q <= tl.req.addr[mem_pkg::ADDR_SIZE-1:2];
            data_q  <= lane_data;
            mask_q  <= tl.req.byte_sel;
        end
    end

    assign hit_o = valid_q && tl.valid && tl.req.rd
                && (waddr_q == tl.req.addr[mem_pkg::ADDR_SIZE-1:2]);
    assign data_o = data_q;
    assign mask_o = mask_q;

    assign full_block_o = valid_q && tl.valid && tl.req.wr && !drain.done;

    assign drain.valid = valid_q;
    assign drain.addr  = {waddr_q, 2'b00};
    assign drain.data  = data_q;
    assign drain.sel   = mask_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_q && !drain.done |=> valid_q && $stable(waddr_q) && $stable(data_q)
                                   && $stable(mask_q));

endmodule : store_buffer

// ==== verilog/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    tl_req_if.align                       tl,
    input  logic [mem_pkg::WORD_SIZE-1:0] cache_data_i,
    input  logic                          cache_hit_i,
    input  logic                          sb_hit_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] sb_data_i,
    input  logic [3:0]                    sb_mask_i,
    output logic [mem_pkg::WORD_SIZE-1:0] data_o,
    output logic                          rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_o
);

    logic [mem_pkg::WORD_SIZE-1:0] merged;
    logic [mem_pkg::WORD_SIZE-1:0] shifted;
    logic [mem_pkg::WORD_SIZE-1:0] load_data;
    logic [mem_pkg::WORD_SIZE-1:0] result;
    logic                          byte_sign;
    logic                          half_sign;

    // Newer store bytes override the cached word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (sb_hit_i && sb_mask_i[b]) begin
                merged[8*b +: 8] = sb_data_i[8*b +: 8];
            end else if (cache_hit_i) begin
                merged[8*b +: 8] = cache_data_i[8*b +: 8];
            end else begin
                merged[8*b +: 8] = 8'h00;
            end
        end
    end

    assign shifted   = merged >> {tl.req.addr[1:0], 3'b000};
    assign byte_sign = tl.req.sign_ext & shifted[7];
    assign half_sign = tl.req.sign_ext & shifted[15];

    always_comb begin
        case (tl.req.mtype)
            mem_pkg::BYTE: load_data = {{(mem_pkg::WORD_SIZE-8){byte_sign}}, shifted[7:0]};
            mem_pkg::HALF: load_data = {{(mem_pkg::WORD_SIZE-16){half_sign}}, shifted[15:0]};
            default:       load_data = shifted;
        endcase
    end

    // Non-loads return the address sum
    assign result = tl.req.rd ? load_data : tl.req.addr;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= tl.valid && tl.req.rf_we && !tl.stall;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tl.valid && !tl.stall) begin
            data_o     <= result;
            rf_waddr_o <= tl.req.rf_waddr;
        end
    end

endmodule : load_align

// ==== verilog/mem_pipeline.sv ====
`timescale 1ns/1ps

module mem_pipeline #(
    parameter int CACHE_LINES = 16
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic [mem_pkg::WORD_SIZE-1:0] src_a_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] src_b_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] st_data_i,
    input  logic                          memop_rd_i,
    input  logic                          memop_wr_i,
    input  logic                          sign_ext_i,
    input  mem_pkg::memop_type_e          memop_type_i,
    input  logic                          rf_we_i,
    input  logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_i,
    input  mem_pkg::bypass_e              bypass_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] bypass_wb_data_i,

    output logic [mem_pkg::WORD_SIZE-1:0] data_o,
    output logic                          rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic                          stall_o,
    output logic                          tl_rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]  tl_rf_waddr_o,

    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic                          wb_we_o,
    output logic [mem_pkg::ADDR_SIZE-1:0] wb_adr_o,
    output logic [mem_pkg::WORD_SIZE-1:0] wb_dat_o,
    output logic [3:0]                    wb_sel_o,
    input  logic [mem_pkg::WORD_SIZE-1:0] wb_dat_i,
    input  logic                          wb_ack_i
);

    tl_req_if   tl ();
    sb_drain_if drain ();

    logic [mem_pkg::ADDR_SIZE-1:0] add_result;
    logic [3:0]                    byte_sel;
    mem_pkg::tl_req_t              tl_q;
    logic                          tl_valid_q;
    mem_pkg::bypass_e              bypass_q;
    logic                          stall;
    logic                          cache_miss;
    logic                          cache_hit;
    logic [mem_pkg::WORD_SIZE-1:0] cache_data;
    logic                          sb_hit;
    logic [mem_pkg::WORD_SIZE-1:0] sb_data;
    logic [3:0]                    sb_mask;
    logic                          sb_full_block;

    assign add_result = $signed(src_a_i) + $signed(src_b_i);

    always_comb begin
        case (memop_type_i)
            mem_pkg::BYTE: byte_sel = 4'b0001 << add_result[1:0];
            mem_pkg::HALF: byte_sel = 4'b0011 << add_result[1:0];
            default:       byte_sel = 4'b1111;
        endcase
    end

    // An operation with no effect enters as a bubble
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tl_valid_q <= 1'b0;
        end else if (!stall) begin
            tl_valid_q <= memop_rd_i | memop_wr_i | rf_we_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            tl_q.addr     <= add_result;
            tl_q.rd       <= memop_rd_i;
            tl_q.wr       <= memop_wr_i;
            tl_q.sign_ext <= sign_ext_i;
            tl_q.mtype    <= memop_type_i;
            tl_q.rf_we    <= rf_we_i;
            tl_q.rf_waddr <= rf_waddr_i;
            tl_q.st_data  <= st_data_i;
            tl_q.byte_sel <= byte_sel;
            bypass_q      <= bypass_i;
        end
    end

    // Late store data from write-back or the MEM result
    always_comb begin
        tl.req = tl_q;
        case (bypass_q)
            mem_pkg::BY_WB:  tl.req.st_data = bypass_wb_data_i;
            mem_pkg::BY_MEM: tl.req.st_data = data_o;
            default:         tl.req.st_data = tl_q.st_data;
        endcase
    end

    assign tl.valid = tl_valid_q;
    assign stall    = cache_miss | sb_full_block;
    assign tl.stall = stall;
    assign stall_o  = stall;

    assign tl_rf_we_o    = tl_valid_q & tl_q.rf_we;
    assign tl_rf_waddr_o = tl_q.rf_waddr;

    dcache_lookup #(
        .CACHE_LINES (CACHE_LINES)
    ) dcache_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .tl       (tl),
        .drain    (drain),
        .data_o   (cache_data),
        .hit_o    (cache_hit),
        .miss_o   (cache_miss),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o),
        .wb_sel_o (wb_sel_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i)
    );

    store_buffer sb_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .tl           (tl),
        .drain        (drain),
        .hit_o        (sb_hit),
        .data_o       (sb_data),
        .mask_o       (sb_mask),
        .full_block_o (sb_full_block)
    );

    load_align align_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .tl           (tl),
        .cache_data_i (cache_data),
        .cache_hit_i  (cache_hit),
        .sb_hit_i     (sb_hit),
        .sb_data_i    (sb_data),
        .sb_mask_i    (sb_mask),
        .data_o       (data_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o)
    );

endmodule : mem_pipeline

// ==== bench/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model #(
    parameter int          DEPTH = 64,
    parameter logic [31:0] SEED  = 32'h1
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    input  logic [3:0]  wb_sel_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [31:0]      mem [DEPTH];
    logic [31:0]      seed;
    logic [31:0]      rnd;
    logic [1:0]       wait_q;
    logic [IDX_W-1:0] idx;

    assign idx = wb_adr_i[IDX_W+1:2];

    // Ack after 0 to 3 wait cycles, single beat per request
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Same fill as the reference model in the testbench
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] = i * 32'h9e37_79b9 + 32'h0f1e_2d3c;
            end
            seed = SEED;
            wb_ack_o <= 1'b0;
            wait_q   <= 2'd1;
        end else if (wb_ack_o) begin
            wb_ack_o <= 1'b0;
        end else if (wb_cyc_i && wb_stb_i) begin
            if (wait_q == 2'd0) begin
                wb_ack_o <= 1'b1;
                wb_dat_o <= mem[idx];
                for (int b = 0; b < 4; b++) begin
                    if (wb_we_i && wb_sel_i[b]) begin
                        mem[idx][8*b +: 8] = wb_dat_i[8*b +: 8];
                    end
                end
                rnd = $random(seed);
                wait_q <= rnd[1:0];
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule : wb_mem_model

// ==== bench/tb_mem_pipeline.sv ====
`timescale 1ns/1ps

module tb_mem_pipeline;

    localparam int WINDOW_WORDS = 64;
    localparam int NUM_OPS      = 2000;
    localparam int STALL_LIMIT  = 200;
    localparam int DRAIN_LIMIT  = 2000;

    typedef struct packed {
        logic [mem_pkg::REG_SIZE-1:0]  dest;
        logic [mem_pkg::WORD_SIZE-1:0] data;
    } result_t;

    typedef struct packed {
        logic [mem_pkg::ADDR_SIZE-1:0] addr;
        logic [3:0]                    sel;
        logic [mem_pkg::WORD_SIZE-1:0] data;
    } bus_write_t;

    logic                          clk_i;
    logic                          rst_n_i;
    logic [mem_pkg::WORD_SIZE-1:0] src_a_i;
    logic [mem_pkg::WORD_SIZE-1:0] src_b_i;
    logic [mem_pkg::WORD_SIZE-1:0] st_data_i;
    logic                          memop_rd_i;
    logic                          memop_wr_i;
    logic                          sign_ext_i;
    mem_pkg::memop_type_e          memop_type_i;
    logic                          rf_we_i;
    logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_i;
    mem_pkg::bypass_e              bypass_i;
    logic [mem_pkg::WORD_SIZE-1:0] bypass_wb_data_i;
    logic [mem_pkg::WORD_SIZE-1:0] data_o;
    logic                          rf_we_o;
    logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_o;
    logic                          stall_o;
    logic                          tl_rf_we_o;
    logic [mem_pkg::REG_SIZE-1:0]  tl_rf_waddr_o;
    logic                          wb_cyc_o;
    logic                          wb_stb_o;
    logic                          wb_we_o;
    logic [mem_pkg::ADDR_SIZE-1:0] wb_adr_o;
    logic [mem_pkg::WORD_SIZE-1:0] wb_dat_o;
    logic [3:0]                    wb_sel_o;
    logic [mem_pkg::WORD_SIZE-1:0] wb_dat_i;
    logic                          wb_ack_i;

    logic [31:0] ref_mem [WINDOW_WORDS];
    result_t     exp_results [$];
    bus_write_t  exp_writes [$];
    logic [31:0] seed;
    logic [31:0] last_result;
    logic        have_last;
    logic        prev_wb_store;
    logic [5:0]  last_store_word;
    logic        checking;
    int          n_loads;
    int          n_reads;

    mem_pipeline #(
        .CACHE_LINES (16)
    ) dut_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .src_a_i          (src_a_i),
        .src_b_i          (src_b_i),
        .st_data_i        (st_data_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .sign_ext_i       (sign_ext_i),
        .memop_type_i     (memop_type_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .bypass_i         (bypass_i),
        .bypass_wb_data_i (bypass_wb_data_i),
        .data_o           (data_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .stall_o          (stall_o),
        .tl_rf_we_o       (tl_rf_we_o),
        .tl_rf_waddr_o    (tl_rf_waddr_o),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_we_o          (wb_we_o),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_o         (wb_dat_o),
        .wb_sel_o         (wb_sel_o),
        .wb_dat_i         (wb_dat_i),
        .wb_ack_i         (wb_ack_i)
    );

    wb_mem_model #(
        .DEPTH (WINDOW_WORDS),
        .SEED  (32'h1a153c40)
    ) mem_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_o),
        .wb_stb_i (wb_stb_o),
        .wb_we_i  (wb_we_o),
        .wb_adr_i (wb_adr_o),
        .wb_dat_i (wb_dat_o),
        .wb_sel_i (wb_sel_o),
        .wb_dat_o (wb_dat_i),
        .wb_ack_o (wb_ack_i)
    );

    always #50 clk_i = ~clk_i;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_data(input string what, input logic [mem_pkg::WORD_SIZE-1:0] got,
                              input logic [mem_pkg::WORD_SIZE-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_dest(input string what, input logic [mem_pkg::REG_SIZE-1:0] got,
                              input logic [mem_pkg::REG_SIZE-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %0d, expected %0d",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_sel(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: wb_sel_o is %b, expected %b",
                                        $time, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] byte_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    task automatic wait_stall_low();
        int cycles;
        cycles = 0;
        while (stall_o) begin
            if (cycles == STALL_LIMIT) begin
                stop_with_failure("Timed out waiting for the pipeline stall to clear");
            end
            @(negedge clk_i);
            cycles++;
        end
    endtask

    task automatic drive_idle();
        src_a_i      = '0;
        src_b_i      = '0;
        st_data_i    = '0;
        memop_rd_i   = 1'b0;
        memop_wr_i   = 1'b0;
        sign_ext_i   = 1'b0;
        memop_type_i = mem_pkg::WORD;
        rf_we_i      = 1'b0;
        rf_waddr_i   = '0;
        bypass_i     = mem_pkg::NO_BYPASS;
    endtask

    // One random load, store or ALU op with the model updated on acceptance
    task automatic drive_random_op();
        logic [31:0] r;
        logic [31:0] r2;
        logic [5:0]  word;
        logic [1:0]  off;
        logic [31:0] addr;
        logic [31:0] value;
        logic [3:0]  sel;
        logic [31:0] lanes;
        result_t     res;
        bus_write_t  wr;
        r  = $random(seed);
        r2 = $random(seed);
        word = (r[12:11] == 2'd0) ? last_store_word : r[10:5];
        case (r[4:3])
            2'd0:    memop_type_i = mem_pkg::BYTE;
            2'd1:    memop_type_i = mem_pkg::HALF;
            default: memop_type_i = mem_pkg::WORD;
        endcase
        case (memop_type_i)
            mem_pkg::BYTE: off = r[15:14];
            mem_pkg::HALF: off = {r[14], 1'b0};
            default:       off = 2'b00;
        endcase
        addr = {24'd0, word, off};
        src_b_i   = r2;
        src_a_i   = addr - r2;
        st_data_i = $random(seed);
        // WB data must hold while a WB-bypassed store sits in TL
        if (!prev_wb_store) begin
            bypass_wb_data_i = $random(seed);
        end
        case (r[17:16])
            2'd0:    bypass_i = mem_pkg::BY_WB;
            2'd1:    bypass_i = have_last ? mem_pkg::BY_MEM : mem_pkg::NO_BYPASS;
            default: bypass_i = mem_pkg::NO_BYPASS;
        endcase
        sign_ext_i = r[18];
        rf_waddr_i = r[23:19];
        memop_rd_i = (r[2:0] < 3'd3);
        memop_wr_i = (r[2:0] >= 3'd3) && (r[2:0] < 3'd6);
        rf_we_i    = !memop_wr_i;
        prev_wb_store = 1'b0;
        if (memop_rd_i) begin
            value = ref_mem[word] >> {off, 3'b000};
            case (memop_type_i)
                mem_pkg::BYTE: value = {{24{sign_ext_i & value[7]}}, value[7:0]};
                mem_pkg::HALF: value = {{16{sign_ext_i & value[15]}}, value[15:0]};
                default:       value = value;
            endcase
            n_loads++;
        end else if (memop_wr_i) begin
            case (bypass_i)
                mem_pkg::BY_WB:  value = bypass_wb_data_i;
                mem_pkg::BY_MEM: value = last_result;
                default:         value = st_data_i;
            endcase
            case (memop_type_i)
                mem_pkg::BYTE: sel = 4'b0001 << off;
                mem_pkg::HALF: sel = 4'b0011 << off;
                default:       sel = 4'b1111;
            endcase
            lanes = (value << {off, 3'b000}) & byte_mask(sel);
            ref_mem[word] = (ref_mem[word] & ~byte_mask(sel)) | lanes;
            wr.addr = {24'd0, word, 2'b00};
            wr.sel  = sel;
            wr.data = lanes;
            exp_writes.push_back(wr);
            last_store_word = word;
            prev_wb_store   = (bypass_i == mem_pkg::BY_WB);
            value = addr;
        end else begin
            src_a_i = $random(seed);
            value   = src_a_i + src_b_i;
        end
        if (rf_we_i) begin
            res.dest = rf_waddr_i;
            res.data = value;
            exp_results.push_back(res);
        end
        last_result = value;
        have_last   = 1'b1;
    endtask

    always @(negedge clk_i) begin
        result_t    res;
        bus_write_t wr;
        if (checking) begin
            if (rf_we_o) begin
                if (exp_results.size() == 0) begin
                    stop_with_failure("Write-back seen with no result pending in the model");
                end
                res = exp_results.pop_front();
                check_data("data_o", data_o, res.data);
                check_dest("rf_waddr_o", rf_waddr_o, res.dest);
            end
            if (wb_cyc_o && wb_stb_o && wb_ack_i) begin
                if (!wb_we_o) begin
                    n_reads++;
                end else if (exp_writes.size() == 0) begin
                    stop_with_failure("Wishbone write seen with no store pending in the model");
                end else begin
                    wr = exp_writes.pop_front();
                    check_data("wb_adr_o", wb_adr_o, wr.addr);
                    check_sel(wb_sel_o, wr.sel);
                    check_data("wb_dat_o", wb_dat_o & byte_mask(wb_sel_o), wr.data);
                end
            end
        end
    end

    initial begin
        int cycles;
        seed             = 32'h1a153c40;
        clk_i            = 1'b0;
        rst_n_i          = 1'b0;
        bypass_wb_data_i = '0;
        checking         = 1'b0;
        have_last        = 1'b0;
        prev_wb_store    = 1'b0;
        last_store_word  = '0;
        last_result      = '0;
        n_loads          = 0;
        n_reads          = 0;
        drive_idle();
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            ref_mem[i] = i * 32'h9e37_79b9 + 32'h0f1e_2d3c;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("rf_we_o", rf_we_o, 1'b0);
        check_flag("wb_cyc_o", wb_cyc_o, 1'b0);
        checking = 1'b1;
        for (int n = 0; n < NUM_OPS; n++) begin
            wait_stall_low();
            drive_random_op();
            @(negedge clk_i);
            // The op just driven now sits in TL
            check_flag("tl_rf_we_o", tl_rf_we_o, rf_we_i);
            check_dest("tl_rf_waddr_o", tl_rf_waddr_o, rf_waddr_i);
        end
        wait_stall_low();
        drive_idle();
        // Remaining results and the last buffered store
        cycles = 0;
        while (exp_results.size() != 0 || exp_writes.size() != 0) begin
            if (cycles == DRAIN_LIMIT) begin
                stop_with_failure("Timed out waiting for pending results and store drain");
            end
            @(negedge clk_i);
            cycles++;
        end
        if (n_reads == 0 || n_reads >= n_loads) begin
            stop_with_failure("Loads never missed or never hit in the data cache");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule : tb_mem_pipeline

// ==== files.f ====
verilog/mem_pkg.sv
verilog/tl_req_if.sv
verilog/sb_drain_if.sv
verilog/dcache_lookup.sv
verilog/store_buffer.sv
verilog/load_align.sv
verilog/mem_pipeline.sv
bench/wb_mem_model.sv
bench/tb_mem_pipeline.sv

// ==== Makefile ====
TOP = tb_mem_pipeline

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -sv --timescale 1ns/1ps \
		--top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
